// ==== Makefile ====
# Verilator build and run for the active list

VERILATOR ?= verilator
TOP       ?= activeList_tb
RTL_TOP   ?= activeList
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

lint:
	$(VERILATOR) --lint-only -Wall --top-module $(RTL_TOP) +incdir+. \
		activeListPkg.sv alBank.sv alDispatch.sv alCommit.sv activeList.sv

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== activeList.sv ====
// Active list top; no overflow check on dispatch, backEndReady_i must respect count_o
`timescale 1ns/1ps
`default_nettype none

`include "activeList_cfg.svh"

module activeList (
	input  wire                                clk,
	input  wire                                reset,
	input  wire                                backEndReady_i,
	input  wire activeListPkg::alDispPkt_t     dispPkt_i [`AL_WIDTH],
	input  wire activeListPkg::alCtrlPkt_t     ctrlPkt_i [`AL_ISSUE],
	output activeListPkg::alId_t               alId_o [`AL_WIDTH],
	output activeListPkg::alId_t               head_o,
	output activeListPkg::alId_t               tail_o,
	output activeListPkg::alCount_t            count_o,
	output activeListPkg::alCommitPkt_t        commitPkt_o [`AL_WIDTH],
	output logic [`AL_WIDTH-1:0]               commitStore_o,
	output logic [`AL_WIDTH-1:0]               commitLoad_o,
	output logic                               recover_o,
	output activeListPkg::pc_t                 recoverPc_o,
	output logic                               exception_o,
	output activeListPkg::pc_t                 exceptionPc_o
);

	logic                      dispEn;
	activeListPkg::alRow_t     tailRow;
	activeListPkg::alId_t      headId;
	logic                      flush;
	logic [`AL_WIDTH_LOG:0]    commitCnt;
	// One head-side entry per bank
	activeListPkg::alEntry_t   bankEntry [`AL_WIDTH];

	alDispatch dispatchCtl (
		.clk            (clk),
		.reset          (reset),
		.backEndReady_i (backEndReady_i),
		.flush_i        (flush),
		.commitCnt_i    (commitCnt),
		.dispEn_o       (dispEn),
		.tailRow_o      (tailRow),
		.alId_o         (alId_o),
		.tail_o         (tail_o),
		.count_o        (count_o)
	);

	// Group lane b always lands in bank b
	for (genvar b = 0; b < `AL_WIDTH; b++)
	begin : bankGen
		alBank #(
			.BANK_ID (b)
		) bank (
			.clk       (clk),
			.reset     (reset),
			.dispEn_i  (dispEn),
			.tailRow_i (tailRow),
			.dispPkt_i (dispPkt_i[b]),
			.ctrlPkt_i (ctrlPkt_i),
			.headId_i  (headId),
			.flush_i   (flush),
			.entry_o   (bankEntry[b])
		);
	end

	alCommit commitCtl (
		.clk           (clk),
		.reset         (reset),
		.entry_i       (bankEntry),
		.count_i       (count_o),
		.headId_o      (headId),
		.head_o        (head_o),
		.flush_o       (flush),
		.commitCnt_o   (commitCnt),
		.commitPkt_o   (commitPkt_o),
		.commitStore_o (commitStore_o),
		.commitLoad_o  (commitLoad_o),
		.recover_o     (recover_o),
		.recoverPc_o   (recoverPc_o),
		.exception_o   (exception_o),
		.exceptionPc_o (exceptionPc_o)
	);

endmodule

`default_nettype wire

// ==== activeListPkg.sv ====
// Types for the active list; all widths come from the shared config macros
`default_nettype none

`include "activeList_cfg.svh"

package activeListPkg;

	// List ID, bank in the low bits and row in the high bits
	typedef logic [`AL_ID_BITS-1:0]  alId_t;
	// Occupancy, 0 up to a full list
	typedef logic [`AL_CNT_BITS-1:0] alCount_t;
	// Row index inside one bank
	typedef logic [`AL_ROW_BITS-1:0] alRow_t;

	typedef logic [`AL_PC_BITS-1:0]  pc_t;
	typedef logic [`AL_LOG_BITS-1:0] logReg_t;
	typedef logic [`AL_PHY_BITS-1:0] phyReg_t;

	// One dispatched instruction, static for its whole life in the list
	typedef struct packed {
		pc_t     pc;
		logReg_t logDest;
		phyReg_t phyDest;
		logic    phyDestValid;
		logic    isStore;
		logic    isLoad;
	} alDispPkt_t;

	// One completion from an issue lane
	typedef struct packed {
		logic    valid;
		alId_t   alId;
		logic    executed;
		logic    mispredict;
		logic    exception;
		// Branch target, only meaningful on a mispredict
		pc_t     nextPc;
	} alCtrlPkt_t;

	// Bank read-out at the head side
	typedef struct packed {
		alDispPkt_t disp;
		logic       executed;
		logic       mispredict;
		logic       exception;
		pc_t        nextPc;
	} alEntry_t;

	// Architectural map update, valid only with a destination
	typedef struct packed {
		logic    valid;
		logReg_t logDest;
		phyReg_t phyDest;
	} alCommitPkt_t;

endpackage

`default_nettype wire

// ==== activeList_cfg.svh ====
// Fixed geometry only: AL_SIZE must be a power of two and a multiple of AL_WIDTH
`ifndef ACTIVELIST_CFG_SVH
`define ACTIVELIST_CFG_SVH

// Number of list entries
`define AL_SIZE        32
// Dispatch and commit group width
`define AL_WIDTH       4
// Completion lanes from the issue side
`define AL_ISSUE       2

// Rows per interleaved bank
`define AL_ROWS        (`AL_SIZE / `AL_WIDTH)

// Field widths
`define AL_PC_BITS     32
`define AL_LOG_BITS    5
`define AL_PHY_BITS    7
`define AL_INSN_BYTES  4

// List ID split: low bits pick the bank, high bits pick the row
`define AL_ID_BITS     5
`define AL_BANK_BITS   2
`define AL_ROW_BITS    3
// Occupancy needs one extra bit to hold a full list
`define AL_CNT_BITS    6
// Commit count is 0 to AL_WIDTH
`define AL_WIDTH_LOG   2

`endif

// ==== activeList_sva.sv ====
// Bound into the commit unit; sees the count, the flag registers and the commit vector
`timescale 1ns/1ps
`default_nettype none

`include "activeList_cfg.svh"

module activeListSva (
	input wire                      clk,
	input wire                      reset,
	input wire [`AL_CNT_BITS-1:0]   count_i,
	input wire                      recover_i,
	input wire                      except_i,
	input wire [`AL_WIDTH-1:0]      commitV_i
);

	// Occupancy bound
	countMax: assert property (@(posedge clk) disable iff (reset)
		count_i <= `AL_SIZE)
		else $error("occupancy above list size");

	// Each flag is a single-cycle pulse
	recoverPulse: assert property (@(posedge clk) disable iff (reset)
		recover_i |=> !recover_i)
		else $error("recover flag longer than one cycle");

	exceptPulse: assert property (@(posedge clk) disable iff (reset)
		except_i |=> !except_i)
		else $error("exception flag longer than one cycle");

	flagsApart: assert property (@(posedge clk) disable iff (reset)
		!(recover_i && except_i))
		else $error("recover and exception flags together");

	// Retire lanes fill from lane 0 with no gaps
	commitContig: assert property (@(posedge clk) disable iff (reset)
		(commitV_i & (commitV_i + 1'b1)) == '0)
		else $error("commit lanes not contiguous");

endmodule

`default_nettype wire

// ==== activeList_tb.sv ====
// Queue-model testbench that applies table rows on falling edges of a 100 ns clock
`timescale 1ns/1ps
`default_nettype none

`include "activeList_cfg.svh"

module activeList_tb;

	// One completion in a row addressed by age from the head
	typedef struct packed {
		logic       valid;
		logic [4:0] age;
		logic       mispredict;
		logic       exception;
	} compSpec_t;

	// Kinds hold {phyDestValid, isStore, isLoad} per lane
	typedef struct packed {
		logic       disp;
		logic [11:0] kinds;
		compSpec_t  c0;
		compSpec_t  c1;
		logic [2:0] expCnt;
		logic       expRec;
		logic       expExc;
	} row_t;

	logic clk;
	logic reset;
	logic backEndReady_i;
	activeListPkg::alDispPkt_t   dispPkt_i [`AL_WIDTH];
	activeListPkg::alCtrlPkt_t   ctrlPkt_i [`AL_ISSUE];
	activeListPkg::alId_t        alId_o [`AL_WIDTH];
	activeListPkg::alId_t        head_o;
	activeListPkg::alId_t        tail_o;
	activeListPkg::alCount_t     count_o;
	activeListPkg::alCommitPkt_t commitPkt_o [`AL_WIDTH];
	logic [`AL_WIDTH-1:0]        commitStore_o;
	logic [`AL_WIDTH-1:0]        commitLoad_o;
	logic                        recover_o;
	activeListPkg::pc_t          recoverPc_o;
	logic                        exception_o;
	activeListPkg::pc_t          exceptionPc_o;

	row_t                    table_q [$];
	activeListPkg::alEntry_t model [$];
	integer                  seed = 9020;
	integer                  errors = 0;
	logic                    recPend;
	logic                    excPend;
	activeListPkg::pc_t      recPc;
	activeListPkg::pc_t      excPc;
	activeListPkg::alId_t    modelHead;
	activeListPkg::alId_t    modelTail;

	activeList DUT (.*);

	bind alCommit activeListSva sva (
		.clk       (clk),
		.reset     (reset),
		.count_i   (count_i),
		.recover_i (recoverReg),
		.except_i  (exceptionReg),
		.commitV_i (commitVec)
	);

	always #50 clk = ~clk;

	// Hard limit on the whole run
	initial
	begin
		repeat (2000) @(posedge clk);
		$display("Simulation timed out before the table finished");
		$display("Errors found");
		$finish;
	end

	task automatic checkVal(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
			errors++;
		end
	endtask

	function automatic compSpec_t makeComp(logic [4:0] age, logic mis, logic exc);
		makeComp = '{valid: 1'b1, age: age, mispredict: mis, exception: exc};
	endfunction

	task automatic addRow(input logic d, input logic [11:0] k, input compSpec_t a,
		input compSpec_t b, input logic [2:0] cnt, input logic rec, input logic exc);
		table_q.push_back('{disp: d, kinds: k, c0: a, c1: b, expCnt: cnt,
			expRec: rec, expExc: exc});
	endtask

	task automatic buildTable();
		// Fill to 16 and complete out of order
		addRow(1, 12'o4251, '0, '0, 0, 0, 0);
		addRow(1, 12'o1054, '0, '0, 0, 0, 0);
		addRow(1, 12'o2415, makeComp(1, 0, 0), makeComp(3, 0, 0), 0, 0, 0);
		addRow(1, 12'o5140, makeComp(0, 0, 0), makeComp(2, 0, 0), 0, 0, 0);
		addRow(0, 12'o0, makeComp(5, 0, 0), makeComp(6, 0, 0), 4, 0, 0);
		addRow(0, 12'o0, makeComp(0, 0, 0), makeComp(4, 0, 0), 0, 0, 0);
		addRow(0, 12'o0, '0, '0, 3, 0, 0);
		// Mispredict completes early in lane 3 and recovers from lane 0
		addRow(0, 12'o0, makeComp(0, 0, 0), makeComp(3, 1, 0), 0, 0, 0);
		addRow(0, 12'o0, makeComp(2, 0, 0), makeComp(4, 0, 0), 2, 0, 0);
		addRow(0, 12'o0, '0, '0, 1, 0, 0);
		addRow(0, 12'o0, '0, '0, 1, 0, 0);
		// Dispatch and completion in the flag cycle are dropped
		addRow(1, 12'o7777, makeComp(0, 0, 0), '0, 0, 1, 0);
		// Exception at the head
		addRow(1, 12'o4444, '0, '0, 0, 0, 0);
		addRow(0, 12'o0, makeComp(0, 0, 1), makeComp(1, 0, 0), 0, 0, 0);
		addRow(0, 12'o0, '0, '0, 0, 0, 0);
		addRow(0, 12'o0, '0, '0, 0, 0, 1);
		// Move the head off the group boundary by two
		addRow(1, 12'($random(seed)), '0, '0, 0, 0, 0);
		addRow(0, 12'o0, makeComp(0, 0, 0), makeComp(1, 0, 0), 0, 0, 0);
		addRow(0, 12'o0, '0, '0, 2, 0, 0);
		// Stream 44 more so four-wide commits straddle rows and the ID wrap
		for (int p = 0; p < 11; p++)
		begin
			addRow(1, 12'($random(seed)), '0, '0, (p == 0) ? 3'd0 : 3'd4, 0, 0);
			addRow(0, 12'o0, makeComp(2, 0, 0), makeComp(3, 0, 0), 0, 0, 0);
			addRow(0, 12'o0, makeComp(0, 0, 0), makeComp(1, 0, 0), 0, 0, 0);
		end
		addRow(0, 12'o0, '0, '0, 4, 0, 0);
		addRow(0, 12'o0, makeComp(0, 0, 0), makeComp(1, 0, 0), 0, 0, 0);
		addRow(0, 12'o0, '0, '0, 2, 0, 0);
		addRow(0, 12'o0, '0, '0, 0, 0, 0);
	endtask

	// Checks the outputs seen now and moves the model across the next rising edge
	task automatic applyRow(input row_t r);
		logic [3:0] vec;
		logic       blocked;
		logic       recNext;
		logic       excNext;
		int         n;
		int         idx;
		compSpec_t  cs;
		activeListPkg::alId_t rel;
		vec = '0;
		blocked = recPend | excPend;
		for (int i = 0; i < 4; i++)
		begin
			vec[i] = !blocked && (i < model.size()) && model[i].executed &&
				!model[i].exception && (i == 0 || !model[i].mispredict);
			if (!vec[i] || model[i].mispredict)
				blocked = 1'b1;
		end
		recNext = vec[0] && model[0].mispredict;
		excNext = !recPend && !excPend && model.size() > 0 && model[0].executed &&
			model[0].exception;
		n = vec[0] + vec[1] + vec[2] + vec[3];
		checkVal(n, r.expCnt, "commit count");
		checkVal(count_o, model.size(), "count");
		checkVal(head_o, modelHead, "head");
		checkVal(tail_o, modelTail, "tail");
		checkVal(recover_o, recPend, "recover flag");
		checkVal(exception_o, excPend, "exception flag");
		checkVal(recPend, r.expRec, "expected recover");
		checkVal(excPend, r.expExc, "expected exception");
		if (recPend)
			checkVal(recoverPc_o, recPc, "recover pc");
		if (excPend)
			checkVal(exceptionPc_o, excPc, "exception pc");
		for (int i = 0; i < 4; i++)
		begin
			checkVal(commitPkt_o[i].valid, vec[i] && model[i].disp.phyDestValid, "map valid");
			if (commitPkt_o[i].valid)
			begin
				checkVal(commitPkt_o[i].logDest, model[i].disp.logDest, "logDest");
				checkVal(commitPkt_o[i].phyDest, model[i].disp.phyDest, "phyDest");
			end
			checkVal(commitStore_o[i], vec[i] && model[i].disp.isStore, "store retire");
			checkVal(commitLoad_o[i],
				vec[i] && model[i].disp.isLoad && model[i].disp.phyDestValid, "load retire");
		end
		// Drive the row with completions addressed from the present head
		backEndReady_i = r.disp;
		for (int i = 0; i < `AL_WIDTH; i++)
		begin
			dispPkt_i[i].pc           = $random(seed) & 32'hffff_fffc;
			dispPkt_i[i].logDest      = 5'($random(seed));
			dispPkt_i[i].phyDest      = 7'($random(seed));
			dispPkt_i[i].phyDestValid = r.kinds[3*i+2];
			dispPkt_i[i].isStore      = r.kinds[3*i+1];
			dispPkt_i[i].isLoad       = r.kinds[3*i];
			if (r.disp && !recPend && !excPend)
				checkVal(alId_o[i], 5'(modelTail + i), "list id");
		end
		for (int j = 0; j < `AL_ISSUE; j++)
		begin
			cs = (j == 0) ? r.c0 : r.c1;
			ctrlPkt_i[j].valid      = cs.valid;
			ctrlPkt_i[j].alId       = modelHead + cs.age;
			ctrlPkt_i[j].executed   = 1'b1;
			ctrlPkt_i[j].mispredict = cs.mispredict;
			ctrlPkt_i[j].exception  = cs.exception;
			ctrlPkt_i[j].nextPc     = $random(seed);
		end
		if (recPend || excPend)
		begin
			// Flush edge empties everything
			model.delete();
			modelHead = '0;
			modelTail = '0;
			recPend = 1'b0;
			excPend = 1'b0;
			return;
		end
		for (int j = 0; j < `AL_ISSUE; j++)
		begin
			// Age from the head modulo the list size
			rel = ctrlPkt_i[j].alId - modelHead;
			idx = rel;
			if (ctrlPkt_i[j].valid && idx < model.size())
			begin
				model[idx].executed   = 1'b1;
				model[idx].mispredict = ctrlPkt_i[j].mispredict;
				model[idx].exception  = ctrlPkt_i[j].exception;
				model[idx].nextPc     = ctrlPkt_i[j].nextPc;
			end
		end
		if (recNext)
			recPc = model[0].nextPc;
		if (excNext)
			excPc = model[0].disp.pc + 4;
		recPend = recNext;
		excPend = excNext;
		repeat (n) void'(model.pop_front());
		modelHead = modelHead + 5'(n);
		if (r.disp)
		begin
			for (int i = 0; i < `AL_WIDTH; i++)
				model.push_back('{disp: dispPkt_i[i], executed: 0, mispredict: 0,
					exception: 0, nextPc: '0});
			modelTail = modelTail + 5'd4;
		end
	endtask

	initial
	begin
		int wait_n;
		clk = 1'b0;
		reset = 1'b1;
		backEndReady_i = 1'b0;
		for (int i = 0; i < `AL_WIDTH; i++)
			dispPkt_i[i] = '0;
		for (int j = 0; j < `AL_ISSUE; j++)
			ctrlPkt_i[j] = '0;
		recPend = 0;
		excPend = 0;
		recPc = '0;
		excPc = '0;
		modelHead = '0;
		modelTail = '0;
		buildTable();
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		foreach (table_q[r])
		begin
			applyRow(table_q[r]);
			$display("test %0d finished, errors so far %0d", r, errors);
			@(negedge clk);
		end
		backEndReady_i = 1'b0;
		// Drain wait with its own bound
		wait_n = 0;
		while (count_o != 0 && wait_n < 20)
		begin
			@(negedge clk);
			wait_n++;
		end
		if (count_o != 0)
		begin
			$display("List did not drain within 20 cycles");
			errors++;
		end
		$display("tests %0d, errors %0d", table_q.size(), errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== alBank.sv ====
// One of AL_WIDTH interleaved banks; holds entries whose list ID modulo AL_WIDTH is BANK_ID
`timescale 1ns/1ps
`default_nettype none

`include "activeList_cfg.svh"

module alBank #(
	parameter int BANK_ID = 0
) (
	input  wire                               clk,
	input  wire                               reset,
	input  wire                               dispEn_i,
	input  wire activeListPkg::alRow_t        tailRow_i,
	input  wire activeListPkg::alDispPkt_t    dispPkt_i,
	input  wire activeListPkg::alCtrlPkt_t    ctrlPkt_i [`AL_ISSUE],
	input  wire activeListPkg::alId_t         headId_i,
	input  wire                               flush_i,
	output activeListPkg::alEntry_t           entry_o
);

	localparam logic [`AL_BANK_BITS-1:0] BANK_SEL = BANK_ID[`AL_BANK_BITS-1:0];

	// Instruction data, written once at dispatch
	activeListPkg::alDispPkt_t dispData [`AL_ROWS];
	// Branch targets from completion
	activeListPkg::pc_t        nextPc   [`AL_ROWS];
	// Completion state per row
	logic [`AL_ROWS-1:0]       executed;
	logic [`AL_ROWS-1:0]       mispredict;
	logic [`AL_ROWS-1:0]       exception;

	logic [`AL_ISSUE-1:0]      ctrlHit;
	activeListPkg::alRow_t     ctrlRow  [`AL_ISSUE];
	activeListPkg::alRow_t     readRow;

	// Completion lanes addressed to this bank
	always_comb
	begin
		for (int i = 0; i < `AL_ISSUE; i++)
		begin
			ctrlHit[i] = ctrlPkt_i[i].valid &&
				(ctrlPkt_i[i].alId[`AL_BANK_BITS-1:0] == BANK_SEL);
			ctrlRow[i] = ctrlPkt_i[i].alId[`AL_ID_BITS-1:`AL_BANK_BITS];
		end
	end

	// Payload storage
	always_ff @(posedge clk)
	begin
		if (dispEn_i)
		begin
			dispData[tailRow_i] <= dispPkt_i;
		end
		for (int i = 0; i < `AL_ISSUE; i++)
		begin
			if (ctrlHit[i])
			begin
				nextPc[ctrlRow[i]] <= ctrlPkt_i[i].nextPc;
			end
		end
	end

	// Completion bits; flush wipes the whole bank
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			executed   <= '0;
			mispredict <= '0;
			exception  <= '0;
		end
		else if (flush_i)
		begin
			executed   <= '0;
			mispredict <= '0;
			exception  <= '0;
		end
		else
		begin
			// New entry starts not executed
			if (dispEn_i)
			begin
				executed[tailRow_i]   <= 1'b0;
				mispredict[tailRow_i] <= 1'b0;
				exception[tailRow_i]  <= 1'b0;
			end
			// Higher lane wins if both hit one row
			for (int i = 0; i < `AL_ISSUE; i++)
			begin
				if (ctrlHit[i])
				begin
					executed[ctrlRow[i]]   <= ctrlPkt_i[i].executed;
					mispredict[ctrlRow[i]] <= ctrlPkt_i[i].mispredict;
					exception[ctrlRow[i]]  <= ctrlPkt_i[i].exception;
				end
			end
		end
	end

	// Banks behind the head bank already hold the next row
	assign readRow = headId_i[`AL_ID_BITS-1:`AL_BANK_BITS] +
		activeListPkg::alRow_t'(BANK_SEL < headId_i[`AL_BANK_BITS-1:0]);

	// Asynchronous head-side read
	always_comb
	begin
		entry_o.disp       = dispData[readRow];
		entry_o.executed   = executed[readRow];
		entry_o.mispredict = mispredict[readRow];
		entry_o.exception  = exception[readRow];
		entry_o.nextPc     = nextPc[readRow];
	end

endmodule

`default_nettype wire

// ==== alCommit.sv ====
// In-order retire of up to AL_WIDTH per cycle; mispredicts and exceptions resolve at lane 0 only
`timescale 1ns/1ps
`default_nettype none

`include "activeList_cfg.svh"

module alCommit (
	input  wire                           clk,
	input  wire                           reset,
	input  wire activeListPkg::alEntry_t  entry_i [`AL_WIDTH],
	input  wire activeListPkg::alCount_t  count_i,
	output activeListPkg::alId_t          headId_o,
	output activeListPkg::alId_t          head_o,
	output logic                          flush_o,
	output logic [`AL_WIDTH_LOG:0]        commitCnt_o,
	output activeListPkg::alCommitPkt_t   commitPkt_o [`AL_WIDTH],
	output logic [`AL_WIDTH-1:0]          commitStore_o,
	output logic [`AL_WIDTH-1:0]          commitLoad_o,
	output logic                          recover_o,
	output activeListPkg::pc_t            recoverPc_o,
	output logic                          exception_o,
	output activeListPkg::pc_t            exceptionPc_o
);

	activeListPkg::alId_t    head;
	logic [`AL_BANK_BITS-1:0] laneBank [`AL_WIDTH];
	// Head-side entries in age order
	activeListPkg::alEntry_t lane [`AL_WIDTH];
	logic [`AL_WIDTH-1:0]    commitVec;
	logic                    mispredHead;
	logic                    exceptHead;
	logic                    recoverReg;
	logic                    exceptionReg;
	activeListPkg::pc_t      recoverPcReg;
	activeListPkg::pc_t      exceptionPcReg;

	// Bank b sits in lane (b - head) mod AL_WIDTH
	always_comb
	begin
		for (int i = 0; i < `AL_WIDTH; i++)
		begin
			laneBank[i] = head[`AL_BANK_BITS-1:0] + `AL_BANK_BITS'(i);
			lane[i]     = entry_i[laneBank[i]];
		end
	end

	// Commit chain, stops at the first lane that cannot go
	always_comb
	begin : commitSel
		logic blocked;
		// Nothing retires while a flush is pending
		blocked = flush_o;
		for (int i = 0; i < `AL_WIDTH; i++)
		begin
			commitVec[i] = ~blocked &
				(count_i > activeListPkg::alCount_t'(i)) &
				lane[i].executed & ~lane[i].exception &
				((i == 0) | ~lane[i].mispredict);
			// A mispredict in lane 0 retires alone
			blocked = blocked | ~commitVec[i] | lane[i].mispredict;
		end
	end

	// Vector is contiguous so the popcount is the retire count
	always_comb
	begin
		commitCnt_o = '0;
		for (int i = 0; i < `AL_WIDTH; i++)
		begin
			commitCnt_o = commitCnt_o + {{`AL_WIDTH_LOG{1'b0}}, commitVec[i]};
		end
	end

	// Lane 0 events
	assign mispredHead = commitVec[0] & lane[0].mispredict;
	assign exceptHead  = ~flush_o & (count_i != '0) &
		lane[0].executed & lane[0].exception;

	// Head pointer and flag registers
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			head         <= '0;
			recoverReg   <= 1'b0;
			exceptionReg <= 1'b0;
		end
		else if (flush_o)
		begin
			head         <= '0;
			recoverReg   <= 1'b0;
			exceptionReg <= 1'b0;
		end
		else
		begin
			head         <= head + activeListPkg::alId_t'(commitCnt_o);
			recoverReg   <= mispredHead;
			exceptionReg <= exceptHead;
		end
	end

	// Restart addresses, captured with their flag
	always_ff @(posedge clk)
	begin
		if (mispredHead)
		begin
			recoverPcReg <= lane[0].nextPc;
		end
		if (exceptHead)
		begin
			// Resume after the faulting instruction
			exceptionPcReg <= lane[0].disp.pc + activeListPkg::pc_t'(`AL_INSN_BYTES);
		end
	end

	assign flush_o       = recoverReg | exceptionReg;
	assign headId_o      = head;
	assign head_o        = head;
	assign recover_o     = recoverReg;
	assign recoverPc_o   = recoverPcReg;
	assign exception_o   = exceptionReg;
	assign exceptionPc_o = exceptionPcReg;

	// Retire outputs, all gated by the commit vector
	always_comb
	begin
		for (int i = 0; i < `AL_WIDTH; i++)
		begin
			commitPkt_o[i].valid   = lane[i].disp.phyDestValid & commitVec[i];
			commitPkt_o[i].logDest = lane[i].disp.logDest;
			commitPkt_o[i].phyDest = lane[i].disp.phyDest;
			commitStore_o[i]       = lane[i].disp.isStore & commitVec[i];
			// Loads count only with a destination
			commitLoad_o[i]        = lane[i].disp.isLoad & lane[i].disp.phyDestValid &
				commitVec[i];
		end
	end

endmodule

`default_nettype wire

// ==== alDispatch.sv ====
// Tail and occupancy only; the caller must not dispatch into a list with fewer than AL_WIDTH free
`timescale 1ns/1ps
`default_nettype none

`include "activeList_cfg.svh"

module alDispatch (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       backEndReady_i,
	input  wire                       flush_i,
	input  wire [`AL_WIDTH_LOG:0]     commitCnt_i,
	output logic                      dispEn_o,
	output activeListPkg::alRow_t     tailRow_o,
	output activeListPkg::alId_t      alId_o [`AL_WIDTH],
	output activeListPkg::alId_t      tail_o,
	output activeListPkg::alCount_t   count_o
);

	activeListPkg::alId_t    tail;
	activeListPkg::alCount_t count;
	activeListPkg::alCount_t dispAdd;

	// Groups arriving during a flush are dropped
	assign dispEn_o  = backEndReady_i & ~flush_i;
	// Tail is group aligned so only the row is needed
	assign tailRow_o = tail[`AL_ID_BITS-1:`AL_BANK_BITS];
	assign tail_o    = tail;
	assign count_o   = count;
	assign dispAdd   = dispEn_o ? activeListPkg::alCount_t'(`AL_WIDTH) : '0;

	// Consecutive IDs from the tail, wrap is free with a power-of-two size
	always_comb
	begin
		for (int i = 0; i < `AL_WIDTH; i++)
		begin
			alId_o[i] = tail + activeListPkg::alId_t'(i);
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			tail  <= '0;
			count <= '0;
		end
		else if (flush_i)
		begin
			tail  <= '0;
			count <= '0;
		end
		else
		begin
			if (dispEn_o)
			begin
				tail <= tail + activeListPkg::alId_t'(`AL_WIDTH);
			end
			// Add the new group, drop what retired
			count <= count + dispAdd - activeListPkg::alCount_t'(commitCnt_i);
		end
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
activeListPkg.sv
alBank.sv
alDispatch.sv
alCommit.sv
activeList.sv
activeList_sva.sv
activeList_tb.sv
